//--- vc_defines.svh
`ifndef VC_DEFINES_SVH
`define VC_DEFINES_SVH

// datapath widths
`define VC_CHAN_W           4       // bits per color channel
`define VC_INTR_W           4       // interrupt sources
`define VC_REG_NUM_W        4       // register number width
`define VC_WORD_W           16      // register data word

// register map
`define VC_REG_SYS_CTRL     0       // mask in [3:0], blend enable
`define VC_REG_INTR_CLEAR   1       // write ones to clear status
`define VC_REG_INTR_STATUS  2       // pending status, read only

// SYS_CTRL fields
`define VC_BLEND_EN_BIT     8       // playfield blend enable

`endif

//--- vc_pkg.sv
`default_nettype none

`include "vc_defines.svh"

package vc_pkg;

    // playfield color word
    //   [15]    A blend mode bit
    //   [15:14] B alpha field
    //   [11:0]  red, green, blue
    typedef logic [4*`VC_CHAN_W-1:0]  xrgb_t;

    typedef logic [`VC_CHAN_W-1:0]    chan_t;       // one channel
    typedef logic [3*`VC_CHAN_W-1:0]  rgb_t;        // packed r,g,b out

    typedef logic [`VC_INTR_W-1:0]    intr_t;       // bit per source

    // cpu register access
    typedef logic [`VC_REG_NUM_W-1:0] reg_num_t;
    typedef logic [`VC_WORD_W-1:0]    reg_word_t;

endpackage

`default_nettype wire

//--- ctrl_if.sv
`default_nettype none
`timescale 1ns/10ps

// control lines from the register block to the logic it steers
interface ctrl_if
    import vc_pkg::*;
();
    intr_t  intr_mask;      // enabled sources
    intr_t  intr_clear;     // one-cycle clear pulse
    intr_t  intr_status;    // pending sources, back to regs for read
    logic   blend_en;       // playfield blending on

    // register block side
    modport regs (
        output intr_mask, intr_clear, blend_en,
        input  intr_status
    );

    modport intr (input intr_mask, intr_clear, output intr_status);

    modport blend (input blend_en);     // pixel pipeline only needs this

endinterface

`default_nettype wire

//--- compositor_regs.sv
`default_nettype none
`timescale 1ns/10ps

`include "vc_defines.svh"

module compositor_regs
    import vc_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       reg_wr_i,       // one-cycle write strobe
    input  wire reg_num_t   reg_num_i,      // register number, write and read
    input  wire reg_word_t  reg_data_i,     // write data
    output reg_word_t       reg_data_o,     // read data, one cycle after reg_num_i
    ctrl_if.regs            ctrl
);

    logic       wr_sys_ctrl;    // write hits SYS_CTRL
    logic       wr_intr_clear;  // write hits INTR_CLEAR
    reg_word_t  rd_word;        // read mux before the output flop

    assign wr_sys_ctrl   = reg_wr_i && (reg_num_i == reg_num_t'(`VC_REG_SYS_CTRL));
    assign wr_intr_clear = reg_wr_i && (reg_num_i == reg_num_t'(`VC_REG_INTR_CLEAR));

    // SYS_CTRL fields and the clear pulse
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ctrl.intr_mask  <= '0;
            ctrl.blend_en   <= 1'b0;
            ctrl.intr_clear <= '0;
        end else begin
            if (wr_sys_ctrl) begin
                ctrl.intr_mask <= reg_data_i[`VC_INTR_W-1:0];
                ctrl.blend_en  <= reg_data_i[`VC_BLEND_EN_BIT];
            end
            // pulse only for the write cycle, zero otherwise
            ctrl.intr_clear <= wr_intr_clear ? reg_data_i[`VC_INTR_W-1:0] : '0;
        end
    end

    // read-back select
    always_comb begin
        rd_word = '0;                   // unused numbers read zero
        case (reg_num_i)
            reg_num_t'(`VC_REG_SYS_CTRL): begin
                rd_word[`VC_INTR_W-1:0]  = ctrl.intr_mask;
                rd_word[`VC_BLEND_EN_BIT] = ctrl.blend_en;
            end
            reg_num_t'(`VC_REG_INTR_STATUS): begin
                rd_word[`VC_INTR_W-1:0] = ctrl.intr_status;
            end
            default: begin
                rd_word = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            reg_data_o <= '0;
        end else begin
            reg_data_o <= rd_word;      // registered, no read strobe
        end
    end

    // clear is a single-cycle pulse per INTR_CLEAR write
    a_clear_pulse: assert property (
        @(posedge clk) disable iff (reset_i)
        (ctrl.intr_clear != '0) |=> (ctrl.intr_clear == '0)
    );

endmodule

`default_nettype wire

//--- intr_ctrl.sv
`default_nettype none
`timescale 1ns/10ps

module intr_ctrl
    import vc_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   reset_i,
    input  wire intr_t  intr_signal_i,  // one-cycle source pulses
    output logic        bus_intr_o,     // cpu interrupt strobe
    ctrl_if.intr        ctrl
);

    intr_t  new_intr;       // signalled, enabled, not yet pending

    // only a fresh unmasked source raises the strobe
    assign new_intr = intr_signal_i & ctrl.intr_mask & ~ctrl.intr_status;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ctrl.intr_status <= '0;
            bus_intr_o       <= 1'b0;
        end else begin
            // pending sources stay set until cleared by cpu
            ctrl.intr_status <= (ctrl.intr_status | intr_signal_i) & ~ctrl.intr_clear;
            bus_intr_o       <= (new_intr != '0);   // one cycle high
        end
    end

    // strobe must trace back to an unmasked source not already pending
    a_strobe_cause: assert property (
        @(posedge clk) disable iff (reset_i)
        bus_intr_o |->
            $past((intr_signal_i & ctrl.intr_mask & ~ctrl.intr_status) != '0)
    );

endmodule

`default_nettype wire

//--- pixel_blend.sv
`default_nettype none
`timescale 1ns/10ps

`include "vc_defines.svh"

module pixel_blend
    import vc_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   reset_i,
    input  wire xrgb_t  color_a_i,      // playfield A, bottom
    input  wire xrgb_t  color_b_i,      // playfield B, drawn on top
    input  wire logic   hsync_i,
    input  wire logic   vsync_i,
    input  wire logic   dv_de_i,        // display enable
    output chan_t       red_o,
    output chan_t       green_o,
    output chan_t       blue_o,
    output logic        hsync_o,
    output logic        vsync_o,
    output logic        dv_de_o,
    ctrl_if.blend       ctrl
);

    // stage 1 stands in for the color memory read
    xrgb_t  color_a_1;
    xrgb_t  color_b_1;
    logic   hsync_1;
    logic   vsync_1;
    logic   dv_de_1;

    logic [2:0] mode;       // {A[15], B[15:14]}
    rgb_t       mix;        // blended color into stage 2

    // one channel of the blend table
    // A is the destination playfield, B the source over it
    function automatic chan_t blend_chan(input chan_t a, input chan_t b,
                                         input logic [2:0] sel);
        logic [`VC_CHAN_W:0] sum;       // carry kept for clamp
        logic [`VC_CHAN_W:0] diff;      // borrow kept for clamp
        chan_t               res;
        sum  = {1'b0, a} + {1'b0, b};
        diff = {1'b0, a} - {1'b0, b};
        case (sel)
            3'b0_00: res = a;                                       // B transparent
            3'b0_01: res = sum[`VC_CHAN_W] ? '1 : sum[`VC_CHAN_W-1:0];   // additive
            3'b0_10: res = sum[`VC_CHAN_W:1];                       // 50/50 mix
            3'b0_11: res = b;                                       // B opaque
            3'b1_00: res = a & b;
            3'b1_01: res = diff[`VC_CHAN_W] ? '0 : diff[`VC_CHAN_W-1:0]; // subtractive
            3'b1_10: res = a | b;
            default: res = sum[`VC_CHAN_W-1:0];                     // wrapping offset blend
        endcase
        return res;
    endfunction

    // stage 1 capture
    always_ff @(posedge clk) begin
        color_a_1 <= color_a_i;         // color payload
        color_b_1 <= color_b_i;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            hsync_1 <= 1'b0;
            vsync_1 <= 1'b0;
            dv_de_1 <= 1'b0;
        end else begin
            hsync_1 <= hsync_i;
            vsync_1 <= vsync_i;
            dv_de_1 <= dv_de_i;
        end
    end

    assign mode = {color_a_1[15], color_b_1[15:14]};

    always_comb begin
        if (ctrl.blend_en) begin
            mix = {blend_chan(color_a_1[11:8], color_b_1[11:8], mode),
                   blend_chan(color_a_1[7:4],  color_b_1[7:4],  mode),
                   blend_chan(color_a_1[3:0],  color_b_1[3:0],  mode)};
        end else begin
            mix = color_a_1[11:0];      // A straight through
        end
    end

    // stage 2 blanks outside the display area
    always_ff @(posedge clk) begin
        if (reset_i) begin
            {red_o, green_o, blue_o} <= '0;
            hsync_o <= 1'b0;
            vsync_o <= 1'b0;
            dv_de_o <= 1'b0;
        end else begin
            {red_o, green_o, blue_o} <= dv_de_1 ? mix : '0;
            hsync_o <= hsync_1;         // syncs keep step with color
            vsync_o <= vsync_1;
            dv_de_o <= dv_de_1;
        end
    end

    // black whenever the delayed enable is low
    a_blank: assert property (
        @(posedge clk) disable iff (reset_i)
        !dv_de_o |-> ({red_o, green_o, blue_o} == '0)
    );

endmodule

`default_nettype wire

//--- video_compositor.sv
`default_nettype none
`timescale 1ns/10ps

module video_compositor
    import vc_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_i,
    // cpu register port
    input  wire logic       reg_wr_i,
    input  wire reg_num_t   reg_num_i,
    input  wire reg_word_t  reg_data_i,
    output reg_word_t       reg_data_o,
    // interrupts
    input  wire intr_t      intr_signal_i,  // source pulses
    output logic            bus_intr_o,     // strobe to cpu
    // playfield colors and timing in
    input  wire xrgb_t      color_a_i,
    input  wire xrgb_t      color_b_i,
    input  wire logic       hsync_i,
    input  wire logic       vsync_i,
    input  wire logic       dv_de_i,
    // video out, two cycles behind
    output chan_t           red_o,
    output chan_t           green_o,
    output chan_t           blue_o,
    output logic            hsync_o,
    output logic            vsync_o,
    output logic            dv_de_o
);

    ctrl_if ctrl_bus ();    // mask, clear, status, blend enable

    compositor_regs u_regs (
        .clk        (clk),
        .reset_i    (reset_i),
        .reg_wr_i   (reg_wr_i),
        .reg_num_i  (reg_num_i),
        .reg_data_i (reg_data_i),
        .reg_data_o (reg_data_o),
        .ctrl       (ctrl_bus.regs)
    );

    intr_ctrl u_intr (
        .clk            (clk),
        .reset_i        (reset_i),
        .intr_signal_i  (intr_signal_i),
        .bus_intr_o     (bus_intr_o),
        .ctrl           (ctrl_bus.intr)
    );

    pixel_blend u_blend (
        .clk        (clk),
        .reset_i    (reset_i),
        .color_a_i  (color_a_i),
        .color_b_i  (color_b_i),
        .hsync_i    (hsync_i),
        .vsync_i    (vsync_i),
        .dv_de_i    (dv_de_i),
        .red_o      (red_o),
        .green_o    (green_o),
        .blue_o     (blue_o),
        .hsync_o    (hsync_o),
        .vsync_o    (vsync_o),
        .dv_de_o    (dv_de_o),
        .ctrl       (ctrl_bus.blend)
    );

endmodule

`default_nettype wire

//--- tb_video_compositor.sv
`default_nettype none
`timescale 1ns/10ps

`include "vc_defines.svh"

module tb_video_compositor
    import vc_pkg::*;
();

    localparam int CLK_PERIOD  = 4;
    localparam int TEST_CYCLES = 260;       // sum over all tests, rounded up
    localparam int MARGIN      = 100;

    logic       clk;
    logic       reset_i;
    logic       reg_wr_i;
    reg_num_t   reg_num_i;
    reg_word_t  reg_data_i;
    reg_word_t  reg_data_o;
    intr_t      intr_signal_i;
    logic       bus_intr_o;
    xrgb_t      color_a_i;
    xrgb_t      color_b_i;
    logic       hsync_i;
    logic       vsync_i;
    logic       dv_de_i;
    chan_t      red_o;
    chan_t      green_o;
    chan_t      blue_o;
    logic       hsync_o;
    logic       vsync_o;
    logic       dv_de_o;

    // pixels in flight, indexed by drive cycle
    xrgb_t      a_q  [64];
    xrgb_t      b_q  [64];
    logic       hs_q [64];
    logic       vs_q [64];
    logic       de_q [64];

    video_compositor u_video_compositor (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // hard stop if a wait never returns
    initial begin
        #((TEST_CYCLES + MARGIN) * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation timed out");
    end

    task automatic fail_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "value mismatch");
    endtask

    task automatic compare_rgb(input string test, input rgb_t expected, input rgb_t actual);
        if (expected !== actual) begin
            $display("** Error %s: expected %h, actual %h", test, expected, actual);
            fail_run();
        end
    endtask

    task automatic compare_word(input string test, input reg_word_t expected,
                                input reg_word_t actual);
        if (expected !== actual) begin
            $display("** Error %s: expected %h, actual %h", test, expected, actual);
            fail_run();
        end
    endtask

    task automatic compare_intr(input string test, input intr_t expected, input intr_t actual);
        if (expected !== actual) begin
            $display("** Error %s: expected %b, actual %b", test, expected, actual);
            fail_run();
        end
    endtask

    task automatic compare_bit(input string test, input logic expected, input logic actual);
        if (expected !== actual) begin
            $display("** Error %s: expected %b, actual %b", test, expected, actual);
            fail_run();
        end
    endtask

    // blend table, one channel at a time on plain integers
    function automatic rgb_t expect_rgb(input xrgb_t a, input xrgb_t b, input logic en);
        rgb_t   res;
        int     c;
        int     ca;
        int     cb;
        int     r;
        int     sel;
        res = '0;
        sel = a[15] ? 4 : 0;
        sel = sel + int'(b[15:14]);
        for (c = 0; c < 3; c++) begin
            ca = int'(a[4*c +: 4]);
            cb = int'(b[4*c +: 4]);
            case (sel)
                0: r = ca;
                1: r = (ca + cb > 15) ? 15 : ca + cb;   // saturate
                2: r = (ca + cb) / 2;
                3: r = cb;
                4: r = ca & cb;
                5: r = (ca - cb < 0) ? 0 : ca - cb;     // floor at black
                6: r = ca | cb;
                default: r = (ca + cb) % 16;
            endcase
            if (!en) begin
                r = ca;         // A passes untouched
            end
            res[4*c +: 4] = 4'(r);
        end
        return res;
    endfunction

    task automatic write_reg(input reg_num_t num, input reg_word_t data);
        reg_wr_i   = 1'b1;
        reg_num_i  = num;
        reg_data_i = data;
        @(negedge clk);
        reg_wr_i   = 1'b0;
        reg_data_i = '0;
    endtask

    // read data lands one edge after the number
    task automatic read_reg(input reg_num_t num, output reg_word_t data);
        reg_num_i = num;
        @(negedge clk);
        data = reg_data_o;
    endtask

    // one pulse, then strobe expected in the first cycle only
    task automatic pulse_source(input string test, input intr_t src, input logic strobe);
        intr_signal_i = src;
        @(negedge clk);
        intr_signal_i = '0;
        compare_bit(test, strobe, bus_intr_o);
        repeat (2) begin
            @(negedge clk);
            compare_bit(test, 1'b0, bus_intr_o);
        end
    endtask

    // drive n pixels, check each two cycles later
    task automatic run_stream(input string test, input int n, input logic en,
                              input logic rand_de, input logic force_modes);
        logic [31:0] w;
        rgb_t        exp_rgb;
        for (int t = 0; t < n + 2; t++) begin
            if (t >= 2) begin
                exp_rgb = de_q[t-2] ? expect_rgb(a_q[t-2], b_q[t-2], en) : '0;
                compare_rgb(test, exp_rgb, {red_o, green_o, blue_o});
                compare_bit(test, hs_q[t-2], hsync_o);
                compare_bit(test, vs_q[t-2], vsync_o);
                compare_bit(test, de_q[t-2], dv_de_o);
            end
            if (t < n) begin
                w = $urandom;
                a_q[t] = w[15:0];
                b_q[t] = w[31:16];
                if (force_modes) begin
                    a_q[t][15]    = t[2];       // walk all eight rules
                    b_q[t][15:14] = t[1:0];
                end
                w = $urandom;
                hs_q[t] = w[0];
                vs_q[t] = w[1];
                de_q[t] = rand_de ? w[2] : 1'b1;
                color_a_i = a_q[t];
                color_b_i = b_q[t];
                hsync_i   = hs_q[t];
                vsync_i   = vs_q[t];
                dv_de_i   = de_q[t];
            end else begin
                dv_de_i = 1'b0;     // drain, blanked
                hsync_i = 1'b0;
                vsync_i = 1'b0;
            end
            @(negedge clk);
        end
    endtask

    task automatic test_reset_state();
        reg_word_t data;
        compare_rgb("reset", '0, {red_o, green_o, blue_o});
        compare_bit("reset hsync", 1'b0, hsync_o);
        compare_bit("reset vsync", 1'b0, vsync_o);
        compare_bit("reset de", 1'b0, dv_de_o);
        compare_bit("reset intr", 1'b0, bus_intr_o);
        read_reg(reg_num_t'(`VC_REG_SYS_CTRL), data);
        compare_word("reset sys_ctrl", '0, data);
        read_reg(reg_num_t'(`VC_REG_INTR_STATUS), data);
        compare_word("reset status", '0, data);
    endtask

    task automatic test_blend_rules();
        reg_word_t data;
        write_reg(reg_num_t'(`VC_REG_SYS_CTRL), 16'h0100);
        read_reg(reg_num_t'(`VC_REG_SYS_CTRL), data);
        compare_word("blend enable", 16'h0100, data);
        run_stream("blend rules", 40, 1'b1, 1'b0, 1'b1);
    endtask

    task automatic test_interrupts();
        reg_word_t data;
        write_reg(reg_num_t'(`VC_REG_SYS_CTRL), 16'h0000);     // all sources masked
        pulse_source("intr masked", 4'b0001, 1'b0);
        read_reg(reg_num_t'(`VC_REG_INTR_STATUS), data);
        compare_intr("intr masked status", 4'b0001, data[`VC_INTR_W-1:0]);
        write_reg(reg_num_t'(`VC_REG_SYS_CTRL), 16'h0002);
        pulse_source("intr unmasked", 4'b0010, 1'b1);
        pulse_source("intr pending", 4'b0010, 1'b0);           // no second strobe
        read_reg(reg_num_t'(`VC_REG_INTR_STATUS), data);
        compare_intr("intr both pending", 4'b0011, data[`VC_INTR_W-1:0]);
        write_reg(reg_num_t'(`VC_REG_INTR_CLEAR), 16'h0002);
        @(negedge clk);     // clear pulse hits status here
        read_reg(reg_num_t'(`VC_REG_INTR_STATUS), data);
        compare_intr("intr cleared", 4'b0001, data[`VC_INTR_W-1:0]);
        pulse_source("intr after clear", 4'b0010, 1'b1);
    endtask

    task automatic test_reg_readback();
        reg_word_t data;
        write_reg(reg_num_t'(`VC_REG_SYS_CTRL), 16'hffff);
        read_reg(reg_num_t'(`VC_REG_SYS_CTRL), data);
        compare_word("sys_ctrl readback", 16'h010f, data);     // only mask and blend bit
        write_reg(reg_num_t'(5), 16'h0000);                    // unused, ignored
        read_reg(reg_num_t'(`VC_REG_SYS_CTRL), data);
        compare_word("unused write", 16'h010f, data);
        for (int n = 0; n < 16; n++) begin
            if (n != `VC_REG_SYS_CTRL && n != `VC_REG_INTR_STATUS) begin
                read_reg(reg_num_t'(n), data);
                compare_word("unused read", '0, data);
            end
        end
    endtask

    initial begin
        void'($urandom(68));
        reset_i       = 1'b1;
        reg_wr_i      = 1'b0;
        reg_num_i     = '0;
        reg_data_i    = '0;
        intr_signal_i = '0;
        color_a_i     = '0;
        color_b_i     = '0;
        hsync_i       = 1'b0;
        vsync_i       = 1'b0;
        dv_de_i       = 1'b0;
        repeat (3) @(negedge clk);
        reset_i = 1'b0;

        test_reset_state();
        run_stream("pipeline timing", 32, 1'b0, 1'b1, 1'b0);
        run_stream("blend off", 24, 1'b0, 1'b0, 1'b0);
        test_blend_rules();
        test_interrupts();
        test_reg_readback();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+.
vc_pkg.sv
ctrl_if.sv
compositor_regs.sv
intr_ctrl.sv
pixel_blend.sv
video_compositor.sv
tb_video_compositor.sv

//--- Makefile
SRCS := $(filter-out +%,$(shell cat all.f)) vc_defines.svh

.PHONY: run clean

obj_dir/Vtb_video_compositor: all.f $(SRCS)
	verilator --binary --timing --assert -f all.f --top-module tb_video_compositor \
		-o Vtb_video_compositor

run: obj_dir/Vtb_video_compositor
	./obj_dir/Vtb_video_compositor | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
